// File: filelist.f
soc_bus_pkg.sv
wb_arbiter.sv
wb_decoder.sv
wb_ram.sv
wb_uart_tx.sv
wb_segdisp.sv
soc_bus_top.sv
tb_soc_bus.sv

// File: soc_bus_pkg.sv
package soc_bus_pkg;

	// Bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int SEL_W  = 4;

	// Address map, slave select in the top nibble
	localparam int SLAVE_FIELD_HI = 31;
	localparam int SLAVE_FIELD_LO = 28;

	localparam logic [3:0] SLV_RAM  = 4'd0;
	localparam logic [3:0] SLV_UART = 4'd1;
	localparam logic [3:0] SLV_SEG  = 4'd2;

	localparam int RAM_WORDS = 256; // Word index from adr[9:2]

	// UART register offsets
	localparam logic [3:0] UART_REG_DATA   = 4'h0;
	localparam logic [3:0] UART_REG_STATUS = 4'h4;

	localparam int UART_CLKS_PER_BIT = 8;

endpackage

// File: soc_bus_top.sv
module soc_bus_top (
	input  logic                              clk,
	input  logic                              rst_n_i,
	input  logic                              m0_cyc_i,
	input  logic                              m0_stb_i,
	input  logic                              m0_we_i,
	input  logic [soc_bus_pkg::ADDR_W-1:0]    m0_adr_i,
	input  logic [soc_bus_pkg::DATA_W-1:0]    m0_dat_i,
	input  logic [soc_bus_pkg::SEL_W-1:0]     m0_sel_i,
	input  logic                              m1_cyc_i,
	input  logic                              m1_stb_i,
	input  logic                              m1_we_i,
	input  logic [soc_bus_pkg::ADDR_W-1:0]    m1_adr_i,
	input  logic [soc_bus_pkg::DATA_W-1:0]    m1_dat_i,
	input  logic [soc_bus_pkg::SEL_W-1:0]     m1_sel_i,
	output logic [soc_bus_pkg::DATA_W-1:0]    m0_dat_o,
	output logic                              m0_ack_o,
	output logic                              m0_err_o,
	output logic [soc_bus_pkg::DATA_W-1:0]    m1_dat_o,
	output logic                              m1_ack_o,
	output logic                              m1_err_o,
	output logic                              tx_o,
	output logic [6:0]                        seg_o
);
	import soc_bus_pkg::*;

	// Shared bus after the arbiter
	logic              bus_cyc;
	logic              bus_stb;
	logic              bus_we;
	logic [ADDR_W-1:0] bus_adr;
	logic [DATA_W-1:0] bus_wdat;
	logic [SEL_W-1:0]  bus_sel;
	logic [DATA_W-1:0] bus_rdat;
	logic              bus_ack;
	logic              bus_err;

	logic              ram_stb;
	logic              uart_stb;
	logic              seg_stb;
	logic [DATA_W-1:0] ram_rdat;
	logic [DATA_W-1:0] uart_rdat;
	logic [DATA_W-1:0] seg_rdat;
	logic              ram_ack;
	logic              uart_ack;
	logic              seg_ack;

	wb_arbiter wb_arbiter_i (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.m0_cyc_i   (m0_cyc_i),
		.m0_stb_i   (m0_stb_i),
		.m0_we_i    (m0_we_i),
		.m0_adr_i   (m0_adr_i),
		.m0_dat_i   (m0_dat_i),
		.m0_sel_i   (m0_sel_i),
		.m1_cyc_i   (m1_cyc_i),
		.m1_stb_i   (m1_stb_i),
		.m1_we_i    (m1_we_i),
		.m1_adr_i   (m1_adr_i),
		.m1_dat_i   (m1_dat_i),
		.m1_sel_i   (m1_sel_i),
		.bus_rdat_i (bus_rdat),
		.bus_ack_i  (bus_ack),
		.bus_err_i  (bus_err),
		.m0_dat_o   (m0_dat_o),
		.m0_ack_o   (m0_ack_o),
		.m0_err_o   (m0_err_o),
		.m1_dat_o   (m1_dat_o),
		.m1_ack_o   (m1_ack_o),
		.m1_err_o   (m1_err_o),
		.bus_cyc_o  (bus_cyc),
		.bus_stb_o  (bus_stb),
		.bus_we_o   (bus_we),
		.bus_adr_o  (bus_adr),
		.bus_wdat_o (bus_wdat),
		.bus_sel_o  (bus_sel)
	);

	wb_decoder wb_decoder_i (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.bus_cyc_i   (bus_cyc),
		.bus_stb_i   (bus_stb),
		.bus_adr_i   (bus_adr),
		.ram_rdat_i  (ram_rdat),
		.ram_ack_i   (ram_ack),
		.uart_rdat_i (uart_rdat),
		.uart_ack_i  (uart_ack),
		.seg_rdat_i  (seg_rdat),
		.seg_ack_i   (seg_ack),
		.ram_stb_o   (ram_stb),
		.uart_stb_o  (uart_stb),
		.seg_stb_o   (seg_stb),
		.bus_rdat_o  (bus_rdat),
		.bus_ack_o   (bus_ack),
		.bus_err_o   (bus_err)
	);

	wb_ram wb_ram_i (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.stb_i   (ram_stb),
		.we_i    (bus_we),
		.adr_i   (bus_adr),
		.dat_i   (bus_wdat),
		.sel_i   (bus_sel),
		.dat_o   (ram_rdat),
		.ack_o   (ram_ack)
	);

	wb_uart_tx wb_uart_tx_i (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.stb_i   (uart_stb),
		.we_i    (bus_we),
		.adr_i   (bus_adr),
		.dat_i   (bus_wdat),
		.dat_o   (uart_rdat),
		.ack_o   (uart_ack),
		.tx_o    (tx_o)
	);

	wb_segdisp wb_segdisp_i (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.stb_i   (seg_stb),
		.we_i    (bus_we),
		.dat_i   (bus_wdat),
		.dat_o   (seg_rdat),
		.ack_o   (seg_ack),
		.seg_o   (seg_o)
	);

endmodule

// File: tb_soc_bus.sv
module tb_soc_bus;
	timeunit 1ns;
	timeprecision 1ps;
	import soc_bus_pkg::*;

	localparam int N_RAND   = 32;
	localparam int N_ARB    = 20;
	localparam int ACCESSES = RAM_WORDS + 2 * N_RAND + N_ARB + 2 * 16 + 8;
	localparam int LIMIT    = ACCESSES * 6 + 3 * 10 * UART_CLKS_PER_BIT + 300;

	localparam logic [ADDR_W-1:0] UART_DATA_ADR = {SLV_UART, 24'd0, UART_REG_DATA};
	localparam logic [ADDR_W-1:0] UART_STAT_ADR = {SLV_UART, 24'd0, UART_REG_STATUS};
	localparam logic [ADDR_W-1:0] SEG_ADR       = {SLV_SEG, 28'd0};
	localparam logic [ADDR_W-1:0] UNMAPPED_ADR  = {4'h7, 28'd0};

	// Segment a in bit 6, g in bit 0
	localparam logic [6:0] SEG_TABLE [16] = '{7'h7e, 7'h30, 7'h6d, 7'h79, 7'h33, 7'h5b,
		7'h5f, 7'h70, 7'h7f, 7'h7b, 7'h77, 7'h1f, 7'h4e, 7'h3d, 7'h4f, 7'h47};

	logic clk = 1'b0;
	logic rst_n_i = 1'b0;
	logic m0_cyc_i, m0_stb_i, m0_we_i, m1_cyc_i, m1_stb_i, m1_we_i;
	logic [ADDR_W-1:0] m0_adr_i, m1_adr_i;
	logic [DATA_W-1:0] m0_dat_i, m1_dat_i, m0_dat_o, m1_dat_o;
	logic [SEL_W-1:0]  m0_sel_i, m1_sel_i;
	logic m0_ack_o, m0_err_o, m1_ack_o, m1_err_o;
	logic tx_o;
	logic [6:0] seg_o;

	logic [31:0]       rng = 32'h9f0b_c3f3;
	logic [DATA_W-1:0] ram_model [RAM_WORDS];
	logic [7:0]        arb_idx [N_ARB/2];
	logic [DATA_W-1:0] arb_dat [N_ARB/2];
	logic [SEL_W-1:0]  arb_sel [N_ARB/2];
	logic              arb_phase = 1'b0;
	logic              unmapped_phase = 1'b0;
	logic [1:0]        arb_last = 2'b00; // Last acked master during arbitration
	int unsigned       cycle_cnt = 0;

	soc_bus_top soc_bus_top_i (.*);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (!arb_phase)
			arb_last <= 2'b00;
		else if (m0_ack_o)
			arb_last <= 2'b01;
		else if (m1_ack_o)
			arb_last <= 2'b10;
	end

	a_resp_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
		!(m0_ack_o && m0_err_o) && !(m1_ack_o && m1_err_o))
		else report_problem("A master saw ack and err in the same cycle");

	a_alternate: assert property (@(posedge clk) disable iff (!rst_n_i)
		arb_phase && (m0_ack_o || m1_ack_o) |->
		(m0_ack_o ? arb_last != 2'b01 : arb_last != 2'b10))
		else report_problem("Arbiter served one master twice while both were requesting");

	a_no_ack_unmapped: assert property (@(posedge clk) disable iff (!rst_n_i)
		unmapped_phase |-> !m0_ack_o && !m1_ack_o)
		else report_problem("Unmapped access returned an ack");

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [ADDR_W-1:0] word_adr(input logic [7:0] idx);
		return {SLV_RAM, {(ADDR_W-14){1'b0}}, idx, 2'b00};
	endfunction

	function automatic logic [DATA_W-1:0] merge_lanes(input logic [DATA_W-1:0] old,
			input logic [DATA_W-1:0] wdat, input logic [SEL_W-1:0] sel);
		logic [DATA_W-1:0] res;
		res = old;
		for (int i = 0; i < SEL_W; i++)
			if (sel[i])
				res[i*8 +: 8] = wdat[i*8 +: 8];
		return res;
	endfunction

	task automatic stop_run();
		$display("Verification failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		$display("ERR %s expected %0h actual %0h", name, exp, act);
		stop_run();
	endtask

	task automatic report_problem(input string msg);
		$display("%s", msg);
		stop_run();
	endtask

	task automatic drive(input int m, input logic req, input logic we,
			input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] wdat,
			input logic [SEL_W-1:0] sel);
		if (m == 0) begin
			m0_cyc_i = req;
			m0_stb_i = req;
			m0_we_i  = we;
			m0_adr_i = adr;
			m0_dat_i = wdat;
			m0_sel_i = sel;
		end else begin
			m1_cyc_i = req;
			m1_stb_i = req;
			m1_we_i  = we;
			m1_adr_i = adr;
			m1_dat_i = wdat;
			m1_sel_i = sel;
		end
	endtask

	// One bus cycle, request held until ack or err
	task automatic access(input int m, input logic we, input logic [ADDR_W-1:0] adr,
			input logic [DATA_W-1:0] wdat, input logic [SEL_W-1:0] sel,
			input logic exp_err, output logic [DATA_W-1:0] rdat);
		logic done;
		logic err;
		done = 1'b0;
		err  = 1'b0;
		@(negedge clk);
		drive(m, 1'b1, we, adr, wdat, sel);
		while (!done) begin
			@(negedge clk);
			err  = (m == 0) ? m0_err_o : m1_err_o;
			done = err || ((m == 0) ? m0_ack_o : m1_ack_o);
		end
		rdat = (m == 0) ? m0_dat_o : m1_dat_o;
		drive(m, 1'b0, 1'b0, '0, '0, '0);
		assert (err == exp_err) else report_mismatch("bus_err", 32'(exp_err), 32'(err));
	endtask

	task automatic write_word(input int m, input logic [7:0] idx,
			input logic [DATA_W-1:0] wdat, input logic [SEL_W-1:0] sel);
		logic [DATA_W-1:0] rdat;
		access(m, 1'b1, word_adr(idx), wdat, sel, 1'b0, rdat);
		ram_model[idx] = merge_lanes(ram_model[idx], wdat, sel);
	endtask

	task automatic check_word(input int m, input logic [7:0] idx, input string name);
		logic [DATA_W-1:0] rdat;
		access(m, 1'b0, word_adr(idx), '0, 4'hf, 1'b0, rdat);
		assert (rdat == ram_model[idx]) else report_mismatch(name, ram_model[idx], rdat);
	endtask

	task automatic write_then_check(input int m, input int k);
		write_word(m, arb_idx[k], arb_dat[k], arb_sel[k]);
		check_word(m, arb_idx[k], "arb_rd");
	endtask

	// Checks every clock of all ten bits, starting at the falling start edge
	task automatic capture_frame(input logic [7:0] data, output int unsigned stop_cycle);
		logic [9:0] frame;
		frame = {1'b1, data, 1'b0};
		do
			@(negedge clk);
		while (tx_o !== 1'b0);
		for (int b = 0; b < 10; b++) begin
			for (int s = 0; s < UART_CLKS_PER_BIT; s++) begin
				if (b != 0 || s != 0)
					@(negedge clk);
				if (b == 9 && s == 0)
					stop_cycle = cycle_cnt;
				assert (tx_o == frame[b])
					else report_mismatch($sformatf("uart_bit%0d", b), 32'(frame[b]), 32'(tx_o));
			end
		end
	endtask

	initial begin : main
		logic [DATA_W-1:0] rdat;
		logic [DATA_W-1:0] stat;
		logic [SEL_W-1:0]  sel;
		logic [7:0]        idx_q [N_RAND];
		logic [7:0]        tx_byte;
		logic [7:0]        tx_next;
		int unsigned       stop_cycle;
		int unsigned       stop_dummy;
		int unsigned       ack_cycle;
		drive(0, 1'b0, 1'b0, '0, '0, '0);
		drive(1, 1'b0, 1'b0, '0, '0, '0);
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n_i = 1'b1;
		@(negedge clk);
		assert (tx_o == 1'b1) else report_mismatch("reset_tx", 1, tx_o);
		assert (seg_o == SEG_TABLE[0]) else report_mismatch("reset_seg", SEG_TABLE[0], seg_o);
		assert (!m0_ack_o && !m0_err_o && !m1_ack_o && !m1_err_o)
			else report_problem("A bus response is high after reset");

		// RAM fill, partial writes from m0, read-back from m1
		for (int i = 0; i < RAM_WORDS; i++) begin
			rng = xorshift(rng);
			write_word(0, 8'(i), rng, 4'hf);
		end
		for (int i = 0; i < N_RAND; i++) begin
			rng = xorshift(rng);
			idx_q[i] = rng[7:0];
			sel      = rng[11:8];
			rng      = xorshift(rng);
			write_word(0, idx_q[i], rng, sel);
		end
		for (int i = 0; i < N_RAND; i++)
			check_word(1, idx_q[i], "ram_rd");

		// Both masters compete, each in its own half of the RAM
		for (int k = 0; k < N_ARB / 2; k++) begin
			rng        = xorshift(rng);
			arb_idx[k] = (k >= N_ARB / 4) ? {1'b1, rng[6:0]} : {1'b0, rng[6:0]};
			arb_sel[k] = rng[11:8];
			rng        = xorshift(rng);
			arb_dat[k] = rng;
		end
		arb_phase = 1'b1;
		fork
			for (int k = 0; k < N_ARB / 4; k++)
				write_then_check(0, k);
			for (int k = N_ARB / 4; k < N_ARB / 2; k++)
				write_then_check(1, k);
		join
		arb_phase = 1'b0;

		// Single UART frame with status polling
		rng = xorshift(rng);
		tx_byte = rng[7:0];
		access(0, 1'b1, UART_DATA_ADR, {24'd0, tx_byte}, 4'h1, 1'b0, rdat);
		fork
			begin
				access(1, 1'b0, UART_STAT_ADR, '0, 4'hf, 1'b0, stat);
				assert (stat == 32'd1) else report_mismatch("uart_status_busy", 1, stat);
			end
			capture_frame(tx_byte, stop_cycle);
		join
		access(1, 1'b0, UART_STAT_ADR, '0, 4'hf, 1'b0, stat);
		assert (stat == 32'd0) else report_mismatch("uart_status_idle", 0, stat);

		// Second write stalls until the first frame ends
		rng = xorshift(rng);
		tx_byte = rng[7:0];
		tx_next = rng[15:8];
		fork
			begin
				access(0, 1'b1, UART_DATA_ADR, {24'd0, tx_byte}, 4'h1, 1'b0, rdat);
				access(0, 1'b1, UART_DATA_ADR, {24'd0, tx_next}, 4'h1, 1'b0, rdat);
				ack_cycle = cycle_cnt;
			end
			begin
				capture_frame(tx_byte, stop_cycle);
				capture_frame(tx_next, stop_dummy);
			end
		join
		assert (ack_cycle > stop_cycle)
			else report_problem("Second UART write was acked before the first stop bit");

		for (int n = 0; n < 16; n++) begin
			access(0, 1'b1, SEG_ADR, 32'(n), 4'hf, 1'b0, rdat);
			assert (seg_o == SEG_TABLE[n])
				else report_mismatch("seg_pattern", 32'(SEG_TABLE[n]), 32'(seg_o));
			access(1, 1'b0, SEG_ADR, '0, 4'hf, 1'b0, rdat);
			assert (rdat == 32'(n)) else report_mismatch("seg_rd", n, rdat);
		end

		unmapped_phase = 1'b1;
		access(0, 1'b1, UNMAPPED_ADR, 32'h1234_5678, 4'hf, 1'b1, rdat);
		unmapped_phase = 1'b0;
		rng = xorshift(rng);
		write_word(0, rng[7:0], rng, 4'hf); // Bus must still work after err
		check_word(1, rng[7:0], "ram_after_err");

		$display("Verification passed");
		$finish;
	end

	initial begin : watchdog
		repeat (LIMIT) @(posedge clk);
		report_problem("Timeout: the tests did not finish in the expected time");
	end

endmodule

// File: wb_arbiter.sv
module wb_arbiter (
	input  logic                              clk,
	input  logic                              rst_n_i,
	input  logic                              m0_cyc_i,
	input  logic                              m0_stb_i,
	input  logic                              m0_we_i,
	input  logic [soc_bus_pkg::ADDR_W-1:0]    m0_adr_i,
	input  logic [soc_bus_pkg::DATA_W-1:0]    m0_dat_i,
	input  logic [soc_bus_pkg::SEL_W-1:0]     m0_sel_i,
	input  logic                              m1_cyc_i,
	input  logic                              m1_stb_i,
	input  logic                              m1_we_i,
	input  logic [soc_bus_pkg::ADDR_W-1:0]    m1_adr_i,
	input  logic [soc_bus_pkg::DATA_W-1:0]    m1_dat_i,
	input  logic [soc_bus_pkg::SEL_W-1:0]     m1_sel_i,
	input  logic [soc_bus_pkg::DATA_W-1:0]    bus_rdat_i,
	input  logic                              bus_ack_i,
	input  logic                              bus_err_i,
	output logic [soc_bus_pkg::DATA_W-1:0]    m0_dat_o,
	output logic                              m0_ack_o,
	output logic                              m0_err_o,
	output logic [soc_bus_pkg::DATA_W-1:0]    m1_dat_o,
	output logic                              m1_ack_o,
	output logic                              m1_err_o,
	output logic                              bus_cyc_o,
	output logic                              bus_stb_o,
	output logic                              bus_we_o,
	output logic [soc_bus_pkg::ADDR_W-1:0]    bus_adr_o,
	output logic [soc_bus_pkg::DATA_W-1:0]    bus_wdat_o,
	output logic [soc_bus_pkg::SEL_W-1:0]     bus_sel_o
);
	logic gnt_valid;
	logic grant;     // 0 = m0, 1 = m1
	logic last;      // Master served last
	logic gnt_cyc;

	assign gnt_cyc = grant ? m1_cyc_i : m0_cyc_i;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			gnt_valid <= 1'b0;
			grant     <= 1'b0;
			last      <= 1'b1; // m0 wins the first tie
		end else if (!gnt_valid) begin
			if (m0_cyc_i || m1_cyc_i) begin
				gnt_valid <= 1'b1;
				grant     <= (m0_cyc_i && m1_cyc_i) ? ~last : m1_cyc_i;
			end
		end else if (!gnt_cyc) begin
			gnt_valid <= 1'b0;
			last      <= grant;
		end
	end

	assign bus_cyc_o  = gnt_valid && gnt_cyc;
	assign bus_stb_o  = gnt_valid && (grant ? m1_stb_i : m0_stb_i);
	assign bus_we_o   = grant ? m1_we_i  : m0_we_i;
	assign bus_adr_o  = grant ? m1_adr_i : m0_adr_i;
	assign bus_wdat_o = grant ? m1_dat_i : m0_dat_i;
	assign bus_sel_o  = grant ? m1_sel_i : m0_sel_i;

	// Responses go back to the owner only
	assign m0_ack_o = gnt_valid && !grant && bus_ack_i;
	assign m0_err_o = gnt_valid && !grant && bus_err_i;
	assign m1_ack_o = gnt_valid && grant && bus_ack_i;
	assign m1_err_o = gnt_valid && grant && bus_err_i;
	assign m0_dat_o = !grant ? bus_rdat_i : '0;
	assign m1_dat_o = grant ? bus_rdat_i : '0;

	a_grant_held: assert property (@(posedge clk) disable iff (!rst_n_i)
		gnt_valid && gnt_cyc |=> gnt_valid && $stable(grant));

	a_one_resp: assert property (@(posedge clk) disable iff (!rst_n_i)
		!((m0_ack_o || m0_err_o) && (m1_ack_o || m1_err_o)));

endmodule

// File: wb_decoder.sv
module wb_decoder (
	input  logic                              clk,
	input  logic                              rst_n_i,
	input  logic                              bus_cyc_i,
	input  logic                              bus_stb_i,
	input  logic [soc_bus_pkg::ADDR_W-1:0]    bus_adr_i,
	input  logic [soc_bus_pkg::DATA_W-1:0]    ram_rdat_i,
	input  logic                              ram_ack_i,
	input  logic [soc_bus_pkg::DATA_W-1:0]    uart_rdat_i,
	input  logic                              uart_ack_i,
	input  logic [soc_bus_pkg::DATA_W-1:0]    seg_rdat_i,
	input  logic                              seg_ack_i,
	output logic                              ram_stb_o,
	output logic                              uart_stb_o,
	output logic                              seg_stb_o,
	output logic [soc_bus_pkg::DATA_W-1:0]    bus_rdat_o,
	output logic                              bus_ack_o,
	output logic                              bus_err_o
);
	import soc_bus_pkg::*;

	logic       req;
	logic       mapped;
	logic [3:0] field;

	assign req   = bus_cyc_i && bus_stb_i;
	assign field = bus_adr_i[SLAVE_FIELD_HI:SLAVE_FIELD_LO];

	assign ram_stb_o  = req && (field == SLV_RAM);
	assign uart_stb_o = req && (field == SLV_UART);
	assign seg_stb_o  = req && (field == SLV_SEG);
	assign mapped     = (field == SLV_RAM) || (field == SLV_UART) || (field == SLV_SEG);

	// Single-cycle err, same latency as a RAM ack
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			bus_err_o <= 1'b0;
		end else begin
			bus_err_o <= req && !mapped && !bus_err_o;
		end
	end

	always_comb begin
		case (field)
			SLV_RAM: begin
				bus_rdat_o = ram_rdat_i;
				bus_ack_o  = ram_ack_i;
			end
			SLV_UART: begin
				bus_rdat_o = uart_rdat_i;
				bus_ack_o  = uart_ack_i;
			end
			SLV_SEG: begin
				bus_rdat_o = seg_rdat_i;
				bus_ack_o  = seg_ack_i;
			end
			default: begin
				bus_rdat_o = '0;
				bus_ack_o  = 1'b0;
			end
		endcase
	end

	a_one_stb: assert property (@(posedge clk) disable iff (!rst_n_i)
		$onehot0({ram_stb_o, uart_stb_o, seg_stb_o}));

endmodule

// File: wb_ram.sv
module wb_ram (
	input  logic                              clk,
	input  logic                              rst_n_i,
	input  logic                              stb_i,
	input  logic                              we_i,
	input  logic [soc_bus_pkg::ADDR_W-1:0]    adr_i,
	input  logic [soc_bus_pkg::DATA_W-1:0]    dat_i,
	input  logic [soc_bus_pkg::SEL_W-1:0]     sel_i,
	output logic [soc_bus_pkg::DATA_W-1:0]    dat_o,
	output logic                              ack_o
);
	import soc_bus_pkg::*;

	logic [DATA_W-1:0]            mem [RAM_WORDS];
	logic [$clog2(RAM_WORDS)-1:0] idx;

	assign idx = adr_i[$clog2(RAM_WORDS)+1:2]; // Word address

	always_ff @(posedge clk) begin
		if (stb_i && !ack_o) begin
			if (we_i) begin
				for (int i = 0; i < SEL_W; i++) begin
					if (sel_i[i])
						mem[idx][i*8 +: 8] <= dat_i[i*8 +: 8];
				end
			end
			dat_o <= mem[idx];
		end
	end

	// No second ack for a stb still held in the ack cycle
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= stb_i && !ack_o;
		end
	end

	a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
		ack_o |=> !ack_o);

endmodule

// File: wb_segdisp.sv
module wb_segdisp (
	input  logic                              clk,
	input  logic                              rst_n_i,
	input  logic                              stb_i,
	input  logic                              we_i,
	input  logic [soc_bus_pkg::DATA_W-1:0]    dat_i,
	output logic [soc_bus_pkg::DATA_W-1:0]    dat_o,
	output logic                              ack_o,
	output logic [6:0]                        seg_o
);
	import soc_bus_pkg::*;

	logic [3:0] nibble;

	// Bit 6 = a ... bit 0 = g, active high
	function automatic logic [6:0] hex_seg(input logic [3:0] n);
		case (n)
			4'h0: return 7'h7e;
			4'h1: return 7'h30;
			4'h2: return 7'h6d;
			4'h3: return 7'h79;
			4'h4: return 7'h33;
			4'h5: return 7'h5b;
			4'h6: return 7'h5f;
			4'h7: return 7'h70;
			4'h8: return 7'h7f;
			4'h9: return 7'h7b;
			4'ha: return 7'h77;
			4'hb: return 7'h1f;
			4'hc: return 7'h4e;
			4'hd: return 7'h3d;
			4'he: return 7'h4f;
			default: return 7'h47;
		endcase
	endfunction

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			nibble <= 4'h0;
			seg_o  <= hex_seg(4'h0);
			ack_o  <= 1'b0;
		end else begin
			ack_o <= stb_i && !ack_o;
			if (stb_i && we_i && !ack_o) begin
				nibble <= dat_i[3:0];
				seg_o  <= hex_seg(dat_i[3:0]);
			end
		end
	end

	assign dat_o = {{(DATA_W-4){1'b0}}, nibble};

endmodule

// File: wb_uart_tx.sv
module wb_uart_tx (
	input  logic                              clk,
	input  logic                              rst_n_i,
	input  logic                              stb_i,
	input  logic                              we_i,
	input  logic [soc_bus_pkg::ADDR_W-1:0]    adr_i,
	input  logic [soc_bus_pkg::DATA_W-1:0]    dat_i,
	output logic [soc_bus_pkg::DATA_W-1:0]    dat_o,
	output logic                              ack_o,
	output logic                              tx_o
);
	import soc_bus_pkg::*;

	logic                                 busy;
	logic                                 data_wr;
	logic [9:0]                           shreg;    // stop, data[7:0], start
	logic [3:0]                           bit_cnt;
	logic [$clog2(UART_CLKS_PER_BIT)-1:0] baud_cnt;

	assign data_wr = stb_i && we_i && (adr_i[3:0] == UART_REG_DATA);

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			shreg    <= '1;
			busy     <= 1'b0;
			bit_cnt  <= '0;
			baud_cnt <= '0;
			tx_o     <= 1'b1;
			ack_o    <= 1'b0;
		end else begin
			tx_o  <= shreg[0]; // Line idles high
			ack_o <= stb_i && !ack_o && !(data_wr && busy);
			if (data_wr && !busy && !ack_o) begin
				shreg    <= {1'b1, dat_i[7:0], 1'b0};
				busy     <= 1'b1;
				bit_cnt  <= '0;
				baud_cnt <= '0;
			end else if (busy) begin
				if (int'(baud_cnt) == UART_CLKS_PER_BIT - 1) begin
					baud_cnt <= '0;
					shreg    <= {1'b1, shreg[9:1]};
					bit_cnt  <= bit_cnt + 4'd1;
					if (bit_cnt == 4'd9)
						busy <= 1'b0; // Frame done
				end else begin
					baud_cnt <= baud_cnt + 1'b1;
				end
			end
		end
	end

	// Status reads busy in bit 0, data register reads as zero
	always_ff @(posedge clk) begin
		if (stb_i) begin
			if (adr_i[3:0] == UART_REG_STATUS)
				dat_o <= {{(DATA_W-1){1'b0}}, busy};
			else
				dat_o <= '0;
		end
	end

	// An acked data write always starts a fresh frame
	a_no_ack_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
		ack_o && $past(data_wr) |-> $rose(busy));

endmodule
